/* hdl/alu_pkg.sv */
// Shared types for the nibble-serial SM83 ALU.
// Modules import this inside their bodies and use scoped names in port lists.
// The control word carries every ALU strobe from the sequencer in one struct.

package alu_pkg;

	localparam int ALU_WIDTH_DEFAULT = 4;                  // Core nibble width.
	localparam int BSEL_W = $clog2(2 * ALU_WIDTH_DEFAULT); // Bit index within a byte.

	// Supported operations.
	typedef enum logic [3:0] {
		OP_ADD,
		OP_ADC,
		OP_SUB,
		OP_SBC,
		OP_AND,
		OP_XOR,
		OP_OR,
		OP_CP,  // Compare, result discarded.
		OP_RL,  // Rotate left through carry.
		OP_RR,  // Rotate right through carry.
		OP_BIT,
		OP_SET,
		OP_RES
	} alu_op_e;

	// Sequencer steps, one per cycle.
	typedef enum logic [2:0] {
		IDLE,
		LOAD_A,
		LOAD_B,
		LOW,   // Low nibble pass.
		HIGH,  // High nibble pass.
		WRITE
	} seq_state_e;

	typedef struct packed {
		logic              load_a;       // Bus into operand A.
		logic              load_b;       // Bus into operand B.
		logic              load_a_zero;
		logic              load_b_zero;
		logic              shift_l;
		logic              shift_r;
		logic              shift_in;     // Bit entering the shifter.
		logic              carry_in;     // Core carry input.
		logic              result_oe;    // Bus sources, at most one.
		logic              shift_oe;
		logic              op_a_oe;
		logic              bs_oe;
		logic              no_carry_out; // R.
		logic              force_carry;  // S.
		logic              ignore_carry; // V.
		logic              negate;       // Invert B into the core.
		logic              op_low;       // 1 selects low half of A.
		logic              op_b_high;    // 1 selects high half of B.
		logic [BSEL_W-1:0] bsel;         // Bit mask index.
	} alu_ctrl_t;

	typedef struct packed {
		logic z;
		logic n;
		logic h;
		logic c;
	} flags_t;

endpackage

/* hdl/sm83_alu.sv */
`timescale 1ns/1ps

// Nibble-serial SM83 ALU datapath.
// A 4-bit ripple core of R/S/V slices does add, AND, OR and XOR.
// Operands reload from the internal bus on the falling clock edge.
// The low-nibble result is held while op_low is set, so the bus
// carries the whole byte during the high pass.

module sm83_alu #(
	parameter int ALU_WIDTH = alu_pkg::ALU_WIDTH_DEFAULT
) (
	input  logic                   clk,
	input  logic [2*ALU_WIDTH-1:0] din,
	input  alu_pkg::alu_ctrl_t     ctrl,
	output logic [2*ALU_WIDTH-1:0] dout,
	output logic                   carry,
	output logic                   zero,
	output logic                   sign,
	output logic                   shift_dbh,
	output logic                   shift_dbl,
	output logic                   daa_l_gt_9,
	output logic                   daa_h_gt_9,
	output logic                   daa_h_eq_9
);

	localparam int WORD_W = 2 * ALU_WIDTH;

	typedef logic [ALU_WIDTH-1:0] nib_t;

	typedef struct packed {
		nib_t h;
		nib_t l;
	} word_t;

	word_t             op_a;     // Operand registers.
	word_t             op_b;
	nib_t              core_a;
	nib_t              core_b;
	nib_t              b_half;
	nib_t              core_res;
	nib_t              res_lo;   // Latched low pass.
	word_t             result;
	word_t             shifted;
	logic [WORD_W-1:0] bit_mask;
	logic [WORD_W-1:0] bus;

	// One core slice. Returns {carry out, result bit}.
	function automatic logic [1:0] slice(input logic a, input logic b, input logic c_in,
			input logic r_sig, input logic s_sig, input logic v_sig);
		logic gen_n;
		logic sum;
		logic c_out;
		gen_n = ~(((a | b) & c_in) | (a & b) | s_sig); // No carry generated.
		sum   = (a & b & c_in) | ((a | b | c_in) & (v_sig | gen_n));
		c_out = ~(r_sig | gen_n);
		return {c_out, sum};
	endfunction

	// Half selection into the core.
	assign core_a = ctrl.op_low ? op_a.l : op_a.h;
	assign b_half = ctrl.op_b_high ? op_b.h : op_b.l;
	assign core_b = ctrl.negate ? ~b_half : b_half; // Subtract and mask clear.

	// Ripple chain.
	always_comb begin
		nib_t r;
		logic c;
		c = ctrl.carry_in;
		for (int i = 0; i < ALU_WIDTH; i++) begin
			{c, r[i]} = slice(core_a[i], core_b[i], c,
				ctrl.no_carry_out, ctrl.force_carry, ctrl.ignore_carry);
		end
		core_res = r;
		carry    = c;
	end

	always_ff @(posedge clk) begin
		if (ctrl.op_low)
			res_lo <= core_res;
	end

	assign result = {core_res, res_lo}; // High pass over held low pass.

	// Shifter works on the input bus.
	always_comb begin
		if (ctrl.shift_r)
			shifted = {ctrl.shift_in, din[WORD_W-1:1]};
		else if (ctrl.shift_l)
			shifted = {din[WORD_W-2:0], ctrl.shift_in};
		else
			shifted = din; // Plain load path.
	end

	assign shift_dbh = din[WORD_W-1]; // Out bit for left rotate.
	assign shift_dbl = din[0];        // Out bit for right rotate.

	assign bit_mask = {{(WORD_W-1){1'b0}}, 1'b1} << ctrl.bsel; // One-hot bit.

	// Bus mux. Sources are exclusive.
	assign bus = ({WORD_W{ctrl.result_oe}} & result)
		| ({WORD_W{ctrl.shift_oe}} & shifted)
		| ({WORD_W{ctrl.op_a_oe}} & op_a)
		| ({WORD_W{ctrl.bs_oe}} & bit_mask);

	always_ff @(negedge clk) begin
		if (ctrl.load_a)
			op_a <= bus;
		else if (ctrl.load_a_zero)
			op_a <= '0;
	end

	always_ff @(negedge clk) begin
		if (ctrl.load_b)
			op_b <= bus;
		else if (ctrl.load_b_zero)
			op_b <= '0;
	end

	assign dout = bus;
	assign zero = ~|bus;
	assign sign = bus[WORD_W-1];

	// Decimal adjust compares, left for a DAA step.
	assign daa_l_gt_9 = op_a.l > 9;
	assign daa_h_gt_9 = op_a.h > 9;
	assign daa_h_eq_9 = op_a.h == 9;

	// The sequencer never drives two bus sources at once.
	a_bus_onehot: assert property (@(posedge clk)
		$onehot0({ctrl.result_oe, ctrl.shift_oe, ctrl.op_a_oe, ctrl.bs_oe}));

	// Only one shift direction is requested.
	a_shift_dir: assert property (@(posedge clk) !(ctrl.shift_l && ctrl.shift_r));

	// Checked on the edge where the loads take effect.
	a_load_a_excl: assert property (@(negedge clk)
		$onehot0({ctrl.load_a, ctrl.load_a_zero}));
	a_load_b_excl: assert property (@(negedge clk)
		$onehot0({ctrl.load_b, ctrl.load_b_zero}));

endmodule

/* hdl/alu_sequencer.sv */
`timescale 1ns/1ps

// Micro-sequencer for the nibble ALU.
// Captures one request on start, then drives the ALU strobes step by step.
// Arithmetic and bit ops run LOAD_A, LOAD_B, LOW, HIGH, WRITE.
// Rotates run LOAD_A then WRITE with the shifter on the bus.
// Raises done for one cycle together with the result byte.

module alu_sequencer #(
	parameter int ALU_WIDTH = alu_pkg::ALU_WIDTH_DEFAULT
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        start,
	input  alu_pkg::alu_op_e            op,
	input  logic [2*ALU_WIDTH-1:0]      a,
	input  logic [2*ALU_WIDTH-1:0]      b,
	input  logic [alu_pkg::BSEL_W-1:0]  bit_idx,
	input  logic [2*ALU_WIDTH-1:0]      dout,
	input  logic                        carry_flag,
	input  logic                        alu_carry,
	output alu_pkg::alu_ctrl_t          ctrl,
	output logic [2*ALU_WIDTH-1:0]      din,
	output logic                        busy,
	output logic                        done,
	output logic [2*ALU_WIDTH-1:0]      result,
	output alu_pkg::seq_state_e         step,
	output alu_pkg::alu_op_e            op_q
);
	import alu_pkg::*;

	localparam int WORD_W = 2 * ALU_WIDTH;

	logic [WORD_W-1:0] a_q;        // Request operands.
	logic [WORD_W-1:0] b_q;
	logic [BSEL_W-1:0] bit_q;
	logic              carry_lo;   // Carry out of the low pass.
	logic              accept;
	logic              is_shift;
	logic              is_bitop;
	logic              is_sub;
	logic              keep_a;     // Result is operand A unchanged.
	logic              first_carry;
	logic [2:0]        rsv;        // {R, S, V} for the core.
	seq_state_e        step_nxt;

	assign accept   = (step == IDLE) && start; // Ignored while busy.
	assign busy     = (step != IDLE);
	assign is_shift = (op_q == OP_RL) || (op_q == OP_RR);
	assign is_bitop = op_q inside {OP_BIT, OP_SET, OP_RES};
	assign is_sub   = op_q inside {OP_SUB, OP_SBC, OP_CP};
	assign keep_a   = (op_q == OP_CP) || (op_q == OP_BIT);

	always_comb begin
		step_nxt = step;
		case (step)
			IDLE:    if (start) step_nxt = LOAD_A;
			LOAD_A:  step_nxt = is_shift ? WRITE : LOAD_B; // Rotates skip the core.
			LOAD_B:  step_nxt = LOW;
			LOW:     step_nxt = HIGH;
			HIGH:    step_nxt = WRITE;
			WRITE:   step_nxt = IDLE;
			default: step_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			step   <= IDLE;
			op_q   <= OP_ADD;
			done   <= 1'b0;
			result <= '0;
		end else begin
			step <= step_nxt;
			done <= (step == WRITE); // One cycle, leaving WRITE.
			if (accept)
				op_q <= op;
			if (step == WRITE)
				result <= keep_a ? a_q : dout;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			a_q   <= a;
			b_q   <= b;
			bit_q <= bit_idx;
		end
		if (step == LOW)
			carry_lo <= alu_carry; // Feeds the high pass.
	end

	// Per-opcode core setup.
	always_comb begin
		first_carry = 1'b0;
		rsv         = 3'b000; // Plain add.
		case (op_q)
			OP_ADC:        first_carry = carry_flag;
			OP_SUB, OP_CP: first_carry = 1'b1; // A + ~B + 1.
			OP_SBC:        first_carry = ~carry_flag; // Borrow in.
			OP_AND, OP_BIT, OP_RES: begin
				first_carry = 1'b1; // AND needs a live carry chain.
				rsv         = 3'b010;
			end
			OP_OR, OP_SET: rsv = 3'b111;
			OP_XOR:        rsv = 3'b100;
			default:       ;
		endcase
	end

	// Strobes for the current step.
	always_comb begin
		ctrl = '0;
		din  = '0;
		case (step)
			LOAD_A: begin
				din           = a_q;
				ctrl.shift_oe = 1'b1; // Unshifted path.
				ctrl.load_a   = 1'b1;
			end
			LOAD_B: begin
				ctrl.load_b = 1'b1;
				if (is_bitop) begin
					ctrl.bs_oe = 1'b1; // B gets the bit mask.
					ctrl.bsel  = bit_q;
				end else begin
					din           = b_q;
					ctrl.shift_oe = 1'b1;
				end
			end
			LOW, HIGH, WRITE: begin
				if (is_shift) begin
					// Only WRITE is reached for rotates.
					din           = a_q;
					ctrl.shift_oe = 1'b1;
					ctrl.shift_l  = (op_q == OP_RL);
					ctrl.shift_r  = (op_q == OP_RR);
					ctrl.shift_in = carry_flag; // Through carry.
				end else begin
					ctrl.result_oe = 1'b1;
					ctrl.op_low    = (step == LOW);
					ctrl.op_b_high = (step != LOW);
					ctrl.negate    = is_sub || (op_q == OP_RES);
					ctrl.carry_in  = (step == LOW) ? first_carry : carry_lo;
					{ctrl.no_carry_out, ctrl.force_carry, ctrl.ignore_carry} = rsv;
				end
			end
			default: ;
		endcase
	end

	// Done never lasts beyond a single cycle.
	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done);

	// A start seen mid-operation neither restarts nor changes the opcode.
	a_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
		busy && start |=> (step != LOAD_A) && $stable(op_q));

endmodule

/* hdl/flag_unit.sv */
`timescale 1ns/1ps

// SM83 flag register.
// Samples the core carry after each nibble pass and the bus zero at WRITE.
// Each opcode updates only the flags it defines. The held carry goes
// back to the sequencer for ADC, SBC and the rotates.

module flag_unit #(
	parameter int ALU_WIDTH = alu_pkg::ALU_WIDTH_DEFAULT
) (
	input  logic                clk,
	input  logic                rst_n,
	input  alu_pkg::seq_state_e step,
	input  alu_pkg::alu_op_e    op,
	input  logic                alu_carry,
	input  logic                zero,
	input  logic                shift_dbh,
	input  logic                shift_dbl,
	output alu_pkg::flags_t     flags,
	output logic                carry_flag
);
	import alu_pkg::*;

	logic is_add;
	logic is_sub;

	// Half carry is the carry out of bit 3.
	if (ALU_WIDTH != 4) begin : g_width_check
		$error("Half carry needs a 4-bit low pass");
	end

	assign is_add = (op == OP_ADD) || (op == OP_ADC);
	assign is_sub = op inside {OP_SUB, OP_SBC, OP_CP};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			flags <= '0;
		end else begin
			case (step)
				LOW: begin
					if (is_add)
						flags.h <= alu_carry;
					else if (is_sub)
						flags.h <= ~alu_carry; // Nibble borrow.
					else if (op == OP_AND || op == OP_BIT)
						flags.h <= 1'b1;
					else if (op == OP_XOR || op == OP_OR)
						flags.h <= 1'b0;
				end
				HIGH: begin
					if (is_add)
						flags.c <= alu_carry;
					else if (is_sub)
						flags.c <= ~alu_carry; // Byte borrow.
					else if (op inside {OP_AND, OP_XOR, OP_OR})
						flags.c <= 1'b0;
				end
				WRITE: begin
					if (op != OP_SET && op != OP_RES) begin
						flags.z <= zero;
						flags.n <= is_sub;
					end
					if (op == OP_RL) begin
						flags.c <= shift_dbh; // Old bit 7.
						flags.h <= 1'b0;
					end
					if (op == OP_RR) begin
						flags.c <= shift_dbl; // Old bit 0.
						flags.h <= 1'b0;
					end
				end
				default: ;
			endcase
		end
	end

	assign carry_flag = flags.c;

	// H and C belong together only when the high pass follows the low pass.
	a_high_after_low: assert property (@(posedge clk) disable iff (!rst_n)
		step == HIGH |-> $past(step) == LOW);

endmodule

/* hdl/alu_top.sv */
`timescale 1ns/1ps

// Byte ALU top level in the SM83 style.
// Pulse start with op, a, b and bit_idx; result and flags are valid with done.
// The DAA compare outputs of the ALU are left open.

module alu_top #(
	parameter int ALU_WIDTH = alu_pkg::ALU_WIDTH_DEFAULT
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       start,
	input  alu_pkg::alu_op_e           op,
	input  logic [2*ALU_WIDTH-1:0]     a,
	input  logic [2*ALU_WIDTH-1:0]     b,
	input  logic [alu_pkg::BSEL_W-1:0] bit_idx,
	output logic                       busy,
	output logic                       done,
	output logic [2*ALU_WIDTH-1:0]     result,
	output alu_pkg::flags_t            flags
);
	import alu_pkg::*;

	alu_ctrl_t              ctrl;
	logic [2*ALU_WIDTH-1:0] din;
	logic [2*ALU_WIDTH-1:0] dout;
	logic                   alu_carry;
	logic                   zero;
	logic                   shift_dbh;
	logic                   shift_dbl;
	logic                   carry_flag;  // Held C, fed back.
	seq_state_e             step;
	alu_op_e                op_q;

	alu_sequencer #(
		.ALU_WIDTH(ALU_WIDTH)
	) u_seq (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.op(op),
		.a(a),
		.b(b),
		.bit_idx(bit_idx),
		.dout(dout),
		.carry_flag(carry_flag),
		.alu_carry(alu_carry),
		.ctrl(ctrl),
		.din(din),
		.busy(busy),
		.done(done),
		.result(result),
		.step(step),
		.op_q(op_q)
	);

	sm83_alu #(
		.ALU_WIDTH(ALU_WIDTH)
	) u_alu (
		.clk(clk),
		.din(din),
		.ctrl(ctrl),
		.dout(dout),
		.carry(alu_carry),
		.zero(zero),
		.sign(),
		.shift_dbh(shift_dbh),
		.shift_dbl(shift_dbl),
		.daa_l_gt_9(),
		.daa_h_gt_9(),
		.daa_h_eq_9()
	);

	flag_unit #(
		.ALU_WIDTH(ALU_WIDTH)
	) u_flags (
		.clk(clk),
		.rst_n(rst_n),
		.step(step),
		.op(op_q),
		.alu_carry(alu_carry),
		.zero(zero),
		.shift_dbh(shift_dbh),
		.shift_dbl(shift_dbl),
		.flags(flags),
		.carry_flag(carry_flag)
	);

endmodule

/* tests/alu_checker.sv */
`timescale 1ns/1ps

// Scoreboard for the SM83 byte ALU.
// Records each accepted request on the rising edge and checks result and
// flags against a reference model when done pulses on the falling edge.
// Model flags carry over between requests, so ADC, SBC and the rotates see the old carry.

module alu_checker (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  alu_pkg::alu_op_e    op,
	input  logic [7:0]          a,
	input  logic [7:0]          b,
	input  logic [2:0]          bit_idx,
	input  logic                busy,
	input  logic                done,
	input  logic [7:0]          result,
	input  alu_pkg::flags_t     flags,
	input  alu_pkg::seq_state_e step
);
	import alu_pkg::*;

	localparam int HANG_CYCLES = 8; // Longest op takes 5.

	typedef struct packed {
		alu_op_e    op;
		logic [7:0] a;
		logic [7:0] b;
		logic [2:0] idx;
	} req_t;

	typedef struct packed {
		logic [7:0] res;
		flags_t     f;
	} ref_out_t;

	req_t       pend_q[$];  // Accepted, not yet done.
	req_t       cur;
	ref_out_t   exp_out;
	flags_t     model_f;    // Flags as the model sees them.
	alu_op_e    op_seen;
	seq_state_e step_seen;
	logic       busy_n = 1'b1; // Busy from the last falling edge.
	logic       in_reset = 1'b0;
	int         wait_cycles = 0;
	int         accept_count = 0;
	int         done_count = 0;
	int         error_count = 0;

	// SM83 byte result and flags for one request.
	function automatic ref_out_t ref_alu(input req_t r, input flags_t f_in);
		ref_out_t   o;
		logic [8:0] wide;
		logic [4:0] half;
		logic       cin;
		logic [7:0] mask;
		o.res = r.a;
		o.f   = f_in; // Untouched flags keep their value.
		mask  = 8'b1 << r.idx;
		cin   = 1'b0;
		case (r.op)
			OP_ADD, OP_ADC: begin
				if (r.op == OP_ADC)
					cin = f_in.c;
				wide  = {1'b0, r.a} + {1'b0, r.b} + {8'b0, cin};
				half  = {1'b0, r.a[3:0]} + {1'b0, r.b[3:0]} + {4'b0, cin};
				o.res = wide[7:0];
				o.f.z = (wide[7:0] == 8'h00);
				o.f.n = 1'b0;
				o.f.h = half[4]; // Carry out of bit 3.
				o.f.c = wide[8];
			end
			OP_SUB, OP_SBC, OP_CP: begin
				if (r.op == OP_SBC)
					cin = f_in.c;
				wide  = {1'b0, r.a} - {1'b0, r.b} - {8'b0, cin};
				half  = {1'b0, r.a[3:0]} - {1'b0, r.b[3:0]} - {4'b0, cin};
				o.res = (r.op == OP_CP) ? r.a : wide[7:0]; // Compare keeps A.
				o.f.z = (wide[7:0] == 8'h00);
				o.f.n = 1'b1;
				o.f.h = half[4]; // Nibble borrow.
				o.f.c = wide[8];
			end
			OP_AND: begin
				o.res = r.a & r.b;
				o.f   = {(o.res == 8'h00), 1'b0, 1'b1, 1'b0}; // H is always set.
			end
			OP_XOR, OP_OR: begin
				o.res = (r.op == OP_XOR) ? (r.a ^ r.b) : (r.a | r.b);
				o.f   = {(o.res == 8'h00), 3'b000};
			end
			OP_RL: begin
				o.res = {r.a[6:0], f_in.c};
				o.f   = {(o.res == 8'h00), 2'b00, r.a[7]};
			end
			OP_RR: begin
				o.res = {f_in.c, r.a[7:1]};
				o.f   = {(o.res == 8'h00), 2'b00, r.a[0]};
			end
			OP_BIT: begin
				o.f.z = ~r.a[r.idx];
				o.f.n = 1'b0;
				o.f.h = 1'b1; // C stays.
			end
			OP_SET:  o.res = r.a | mask;
			OP_RES:  o.res = r.a & ~mask;
			default: ;
		endcase
		return o;
	endfunction

	// One pass per clock: requests on the rise, outputs on the fall.
	initial begin
		model_f = '0;
		forever begin
			@(posedge clk);
			if (!rst_n) begin
				pend_q.delete();
				model_f  = '0;
				in_reset = 1'b1;
			end else begin
				in_reset = 1'b0;
				if (start && !busy_n) begin // Same rule as the DUT.
					cur.op  = op;
					cur.a   = a;
					cur.b   = b;
					cur.idx = bit_idx;
					pend_q.push_back(cur);
					accept_count++;
					wait_cycles = 0;
				end
			end
			@(negedge clk);
			busy_n = busy;
			if (in_reset && (busy !== 1'b0 || done !== 1'b0 || result !== 8'h00
					|| flags !== 4'h0)) begin
				$display("error at %0t ns: outputs not cleared in reset", $time);
				error_count++;
			end
			if (done) begin
				done_count++;
				if (pend_q.size() == 0) begin
					$display("A done pulse came at %0t ns with no request pending", $time);
					error_count++;
				end else begin
					cur     = pend_q.pop_front();
					op_seen = cur.op;
					exp_out = ref_alu(cur, model_f);
					if (result !== exp_out.res || flags !== exp_out.f) begin
						$display("error at %0t ns: %s a=%02h b=%02h bit %0d gave %02h flags %b, expected %02h flags %b",
							$time, op_seen.name(), cur.a, cur.b, cur.idx,
							result, flags, exp_out.res, exp_out.f);
						error_count++;
					end
					model_f = exp_out.f; // Carry chain follows the model.
				end
			end
			if (pend_q.size() > 0) begin
				wait_cycles++;
				if (wait_cycles == HANG_CYCLES) begin
					op_seen   = pend_q[0].op;
					step_seen = step;
					$display("Request %s got no done after %0d cycles, sequencer stuck in %s",
						op_seen.name(), wait_cycles, step_seen.name());
					error_count++;
				end
			end
		end
	end

endmodule

/* tests/tb_alu_top.sv */
`timescale 1ns/1ps

// Testbench for the SM83 byte ALU.
// Drives requests on the falling edge, waits for done and lets alu_checker
// compare each answer. Prints one line per test and a closing summary.

module tb_alu_top;
	import alu_pkg::*;

	localparam int N_DIRECTED  = 6;
	localparam int N_ARITH     = 200;
	localparam int N_LOGIC     = 100;
	localparam int N_ROTATE    = 32;
	localparam int N_BIT_BYTES = 4;
	localparam int N_SETRES    = 16;
	localparam int N_BUSY      = 8;
	localparam int N_REQUESTS  = 1 + N_DIRECTED + N_ARITH + N_LOGIC + N_ROTATE
		+ N_BIT_BYTES * 9 + 2 * N_SETRES + N_BUSY;
	localparam int MAX_CYCLES  = 8 * N_REQUESTS + 50; // Margin covers reset and idle gaps.

	logic       clk;
	logic       rst_n;
	logic       start;
	alu_op_e    op;
	logic [7:0] a;
	logic [7:0] b;
	logic [2:0] bit_idx;
	logic       busy;
	logic       done;
	logic [7:0] result;
	flags_t     flags;
	seq_state_e seq_step;   // For the hang message.
	int         cycles = 0;
	int         issued;     // Requests meant to be accepted.
	int         tb_errors;
	int         tests_failed;
	int         err_mark;

	alu_top UUT (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.op(op),
		.a(a),
		.b(b),
		.bit_idx(bit_idx),
		.busy(busy),
		.done(done),
		.result(result),
		.flags(flags)
	);

	assign seq_step = UUT.step;

	alu_checker chk (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.op(op),
		.a(a),
		.b(b),
		.bit_idx(bit_idx),
		.busy(busy),
		.done(done),
		.result(result),
		.flags(flags),
		.step(seq_step)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period.
	end

	// Whole-run watchdog.
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES) begin
			$display("Run stopped at the limit of %0d cycles, the DUT stopped answering",
				MAX_CYCLES);
			$display("Checks failed");
			$finish;
		end
	end

	// Called on a falling edge; returns on the falling edge that sees done.
	task run_op(input alu_op_e o, input logic [7:0] x, input logic [7:0] y,
			input logic [2:0] idx);
		op      = o;
		a       = x;
		b       = y;
		bit_idx = idx;
		start   = 1'b1;
		issued++;
		@(negedge clk);
		start = 1'b0;
		while (!done)
			@(negedge clk);
	endtask

	// ADD with a second start two cycles in, which must be dropped.
	task run_busy(input logic [7:0] x, input logic [7:0] y);
		op    = OP_ADD;
		a     = x;
		b     = y;
		start = 1'b1;
		issued++;
		@(negedge clk);
		start = 1'b0;
		@(negedge clk);
		op    = OP_XOR; // Busy, ignored.
		a     = ~x;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		while (!done)
			@(negedge clk);
	endtask

	task report_test(input string name, input int n_ops);
		int errs;
		errs = chk.error_count + tb_errors - err_mark;
		if (errs != 0)
			tests_failed++;
		$display("%s: %0d requests, %0d errors", name, n_ops, errs);
		err_mark = chk.error_count + tb_errors;
	endtask

	initial begin
		logic [7:0] x;
		int         k;
		alu_op_e    o;
		rst_n        = 1'b0;
		start        = 1'b0;
		op           = OP_ADD;
		a            = 8'h00;
		b            = 8'h00;
		bit_idx      = 3'd0;
		issued       = 0;
		tb_errors    = 0;
		tests_failed = 0;
		err_mark     = 0;
		void'($urandom(77));
		repeat (4) @(negedge clk); // Four cycles of reset.

		rst_n = 1'b1;
		run_op(OP_ADD, 8'h12, 8'h34, 3'd0); // Start right out of reset.
		repeat (3) @(negedge clk);
		if (chk.accept_count != 1 || chk.done_count != 1 || busy) begin
			$display("Start at the end of reset did not give exactly one operation");
			tb_errors++;
		end
		report_test("Test 1 reset and first start", 1);

		run_op(OP_ADD, 8'h0F, 8'h01, 3'd0); // Half carry only.
		run_op(OP_ADD, 8'hFF, 8'h01, 3'd0); // Z, H and C.
		run_op(OP_ADC, 8'h0E, 8'h01, 3'd0); // Carry in from above.
		run_op(OP_SUB, 8'h00, 8'h01, 3'd0); // Borrow from both nibbles.
		run_op(OP_SBC, 8'h10, 8'h0F, 3'd0); // Borrow in, result zero.
		run_op(OP_CP, 8'h3C, 8'h3C, 3'd0);
		for (int i = 0; i < N_ARITH; i++) begin
			k = $urandom_range(4, 0);
			case (k)
				0:       o = OP_ADD;
				1:       o = OP_ADC;
				2:       o = OP_SUB;
				3:       o = OP_SBC;
				default: o = OP_CP;
			endcase
			run_op(o, 8'($urandom), 8'($urandom), 3'd0);
		end
		report_test("Test 2 add, subtract and compare", N_DIRECTED + N_ARITH);

		for (int i = 0; i < N_LOGIC; i++) begin
			k = $urandom_range(2, 0);
			o = (k == 0) ? OP_AND : ((k == 1) ? OP_XOR : OP_OR);
			run_op(o, 8'($urandom), 8'($urandom), 3'd0);
		end
		report_test("Test 3 logic ops", N_LOGIC);

		x = 8'($urandom);
		for (int i = 0; i < N_ROTATE; i++) begin
			o = ($urandom_range(1, 0) == 0) ? OP_RL : OP_RR;
			run_op(o, x, 8'h00, 3'd0);
			x = result; // Chain the rotated byte.
		end
		report_test("Test 4 rotates through carry", N_ROTATE);

		for (int j = 0; j < N_BIT_BYTES; j++) begin
			run_op(OP_ADD, 8'h80, (j % 2 == 0) ? 8'h80 : 8'h00, 3'd0); // Sets or clears C.
			x = 8'($urandom);
			for (int i = 0; i < 8; i++)
				run_op(OP_BIT, x, 8'h00, 3'(i));
		end
		for (int i = 0; i < N_SETRES; i++) begin
			run_op(OP_SET, 8'($urandom), 8'h00, 3'($urandom));
			run_op(OP_RES, 8'($urandom), 8'h00, 3'($urandom));
		end
		report_test("Test 5 bit test, set and reset", N_BIT_BYTES * 9 + 2 * N_SETRES);

		for (int i = 0; i < N_BUSY; i++)
			run_busy(8'($urandom), 8'($urandom));
		repeat (4) @(negedge clk); // Room for a stray done.
		if (chk.accept_count != issued || chk.done_count != issued) begin
			$display("Accepted %0d and done %0d do not match %0d issued requests",
				chk.accept_count, chk.done_count, issued);
			tb_errors++;
		end
		report_test("Test 6 start while busy", N_BUSY);

		$display("Summary: 6 tests, %0d failed, %0d requests, %0d done, %0d errors",
			tests_failed, issued, chk.done_count, chk.error_count + tb_errors);
		if (tests_failed == 0 && chk.error_count + tb_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* verilog.f */
hdl/alu_pkg.sv
hdl/sm83_alu.sv
hdl/alu_sequencer.sv
hdl/flag_unit.sv
hdl/alu_top.sv
tests/alu_checker.sv
tests/tb_alu_top.sv

/* Makefile */
# Verilator build and run for the SM83 byte ALU testbench.
# Override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_alu_top
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= All checks passed

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation result: pass"; \
	else \
		echo "Simulation result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
